// File: verilog/wb_pkg.sv
package wb_pkg;

    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_alu   = 3'd1,
        op_csr   = 3'd2,
        op_div   = 3'd3,
        op_load  = 3'd4,
        op_store = 3'd5
    } op_class_e;

    typedef struct packed {
        op_class_e op_class;
        // remainder when set, quotient when clear
        logic      div_rem;
    } uop_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        uop_t        uop;
        logic [4:0]  rd;
        logic [31:0] result;
        logic        result_valid;
    } lane_in_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_port_t;

    // loongarch estat codes plus an out of range exp_none
    typedef enum logic [6:0] {
        exp_int  = 7'h00,
        exp_pil  = 7'h01,
        exp_pis  = 7'h02,
        exp_pif  = 7'h03,
        exp_pme  = 7'h04,
        exp_ppi  = 7'h07,
        exp_adef = 7'h08,
        exp_ale  = 7'h09,
        exp_sys  = 7'h0b,
        exp_brk  = 7'h0c,
        exp_ine  = 7'h0d,
        exp_tlbr = 7'h3f,
        exp_none = 7'h7f
    } ecode_e;

    typedef struct packed {
        logic        flag;
        ecode_e      ecode;
        logic [31:0] badv;
        logic [31:0] era;
    } exc_in_t;

    typedef struct packed {
        logic        flush;
        logic [6:0]  ecode;
        logic [31:0] badv;
        logic        wen_badv;
        logic [18:0] vppn;
        logic        wen_vppn;
        logic [31:0] era;
        logic        wen_era;
        logic        tlb_refill;
    } exc_out_t;

endpackage

// File: verilog/wb_lane_select.sv
`timescale 1ns/10ps

module wb_lane_select
    import wb_pkg::*;
#(
    parameter bit has_csr = 1'b1
) (
    input  logic        clk,
    input  logic        aresetn,
    input  lane_in_t    lane,
    input  logic [31:0] csr_data,
    input  logic        csr_ready,
    input  logic [31:0] quotient,
    input  logic [31:0] remainder,
    input  logic        div_ready,
    input  logic [31:0] dcache_data,
    input  logic        dcache_ready,
    output wb_port_t    wb,
    output logic        done
);
    logic        is_csr;
    logic        sel_we;
    logic [31:0] sel_data;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    assign is_csr = has_csr && (lane.uop.op_class == op_csr);

    // result_valid first, then csr, div, load
    always_comb begin
        sel_we   = 1'b0;
        sel_data = '0;
        done     = 1'b1;
        if (lane.result_valid) begin
            sel_we   = 1'b1;
            sel_data = lane.result;
        end else if (is_csr) begin
            sel_we   = csr_ready;
            sel_data = csr_data;
            done     = csr_ready;
        end else if (lane.uop.op_class == op_div) begin
            sel_we   = div_ready;
            sel_data = lane.uop.div_rem ? remainder : quotient;
            done     = div_ready;
        end else if (lane.uop.op_class == op_load) begin
            sel_we   = dcache_ready;
            sel_data = dcache_data;
            done     = dcache_ready;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= sel_we && (lane.rd != 5'd0);
        end
    end

    // stores, bubbles and stalled lanes leave a cleared port
    always_ff @(posedge clk) begin
        wb_rd   <= sel_we ? lane.rd : 5'd0;
        wb_data <= sel_data;
    end

    assign wb = '{we: wb_we, rd: wb_rd, data: wb_data};

    // csr read aimed at r0 never shows up as a write
    assert property (@(posedge clk) disable iff (!aresetn)
        (is_csr && csr_ready && !lane.result_valid && lane.rd == 5'd0) |=> !wb.we);

endmodule

// File: verilog/exc_commit.sv
`timescale 1ns/10ps

module exc_commit
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  exc_in_t     exc,
    input  logic        cpu_interrupt,
    input  logic [31:0] eentry,
    input  logic [31:0] tlbrentry,
    output exc_out_t    exc_out,
    output logic [31:0] pc_from_wb
);
    logic        set_badv;
    logic        set_vppn;
    logic        flush_q;
    logic        wen_badv_q;
    logic        wen_vppn_q;
    logic        wen_era_q;
    logic        tlb_refill_q;
    logic [6:0]  ecode_q;
    logic [31:0] badv_q;
    logic [31:0] era_q;

    // page faults, address errors and tlb refill carry a bad address
    assign set_badv = exc.ecode inside {exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi,
                                        exp_adef, exp_ale, exp_tlbr};
    assign set_vppn = exc.ecode inside {exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi,
                                        exp_tlbr};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush_q      <= 1'b0;
            wen_badv_q   <= 1'b0;
            wen_vppn_q   <= 1'b0;
            wen_era_q    <= 1'b0;
            tlb_refill_q <= 1'b0;
        end else begin
            flush_q      <= exc.flag || cpu_interrupt;
            wen_badv_q   <= exc.flag && set_badv;
            wen_vppn_q   <= exc.flag && set_vppn;
            wen_era_q    <= exc.flag || cpu_interrupt;
            tlb_refill_q <= exc.flag && (exc.ecode == exp_tlbr);
        end
    end

    // interrupt alone reports as exp_int
    always_ff @(posedge clk) begin
        ecode_q <= (cpu_interrupt && !exc.flag) ? exp_int : exc.ecode;
        badv_q  <= exc.badv;
        era_q   <= exc.era;
    end

    assign exc_out = '{flush: flush_q, ecode: ecode_q, badv: badv_q, wen_badv: wen_badv_q,
                       vppn: badv_q[18:0], wen_vppn: wen_vppn_q, era: era_q,
                       wen_era: wen_era_q, tlb_refill: tlb_refill_q};

    assign pc_from_wb = tlb_refill_q ? tlbrentry : eentry;

    assert property (@(posedge clk) disable iff (!aresetn)
        (exc_out.wen_badv || exc_out.wen_vppn || exc_out.wen_era) |-> exc_out.flush);

endmodule

// File: verilog/iter_divider.sv
`timescale 1ns/10ps

module iter_divider #(
    parameter int div_iters = 32
) (
    input  logic        clk,
    input  logic        aresetn,
    input  logic        start,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic [31:0] remainder,
    output logic        busy,
    output logic        ready
);
    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_e;

    localparam int cnt_w     = $clog2(div_iters + 1);
    localparam int pre_shift = 32 - div_iters;

    div_state_e       state;
    logic [cnt_w-1:0] cnt;
    logic             by_zero;
    logic [31:0]      q_q;
    logic [31:0]      r_q;
    logic [31:0]      d_q;
    logic [32:0]      shifted;
    logic [32:0]      trial;

    // bring in next dividend bit, try subtracting
    assign shifted = {r_q, q_q[31]};
    assign trial   = shifted - {1'b0, d_q};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= div_idle;
            cnt     <= '0;
            by_zero <= 1'b0;
        end else begin
            case (state)
                div_idle: begin
                    if (start) begin
                        state   <= div_run;
                        cnt     <= '0;
                        by_zero <= (divisor == '0);
                    end
                end
                div_run: begin
                    if (cnt == cnt_w'(div_iters - 1)) begin
                        state <= div_done;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_idle && start) begin
            d_q <= divisor;
            if (divisor == '0) begin
                q_q <= '1;
                r_q <= dividend;
            end else begin
                // top operand bit lands in q_q[31]
                q_q <= dividend << pre_shift;
                r_q <= '0;
            end
        end else if (state == div_run && !by_zero) begin
            if (!trial[32]) begin
                r_q <= trial[31:0];
                q_q <= {q_q[30:0], 1'b1};
            end else begin
                r_q <= shifted[31:0];
                q_q <= {q_q[30:0], 1'b0};
            end
        end
    end

    assign quotient  = q_q;
    assign remainder = r_q;
    assign busy      = (state != div_idle);
    assign ready     = (state == div_done);

    assert property (@(posedge clk) disable iff (!aresetn) start |-> !busy);

endmodule

// File: verilog/dual_regfile.sv
`timescale 1ns/10ps

module dual_regfile
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  wb_port_t    wb0,
    input  wb_port_t    wb1,
    input  logic [4:0]  rd_addr0,
    input  logic [4:0]  rd_addr1,
    output logic [31:0] rd_data0,
    output logic [31:0] rd_data1
);
    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0.we && wb0.rd != 5'd0) begin
                regs[wb0.rd] <= wb0.data;
            end
            // second write wins on a shared rd
            if (wb1.we && wb1.rd != 5'd0) begin
                regs[wb1.rd] <= wb1.data;
            end
        end
    end

    assign rd_data0 = (rd_addr0 == 5'd0) ? 32'd0 : regs[rd_addr0];
    assign rd_data1 = (rd_addr1 == 5'd0) ? 32'd0 : regs[rd_addr1];

endmodule

// File: verilog/ex2_wb_stage.sv
`timescale 1ns/10ps

module ex2_wb_stage
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  lane_in_t    lane0,
    input  lane_in_t    lane1,
    input  logic [31:0] csr_data,
    input  logic        csr_ready,
    input  logic [31:0] dcache_data,
    input  logic        dcache_ready,
    input  logic [31:0] quotient,
    input  logic [31:0] remainder,
    input  logic        div_ready,
    input  logic        div_busy,
    input  exc_in_t     exc,
    input  logic        cpu_interrupt,
    input  logic [31:0] eentry,
    input  logic [31:0] tlbrentry,
    output logic        allowin,
    output logic        div_start,
    output wb_port_t    wb0,
    output wb_port_t    wb1,
    output exc_out_t    exc_out,
    output logic [31:0] pc_from_wb,
    output logic [31:0] dbg0_pc,
    output logic [31:0] dbg0_inst,
    output logic [31:0] dbg1_pc,
    output logic [31:0] dbg1_inst,
    output logic        dbg_valid
);
    logic done0;
    logic done1;
    logic bubble;
    logic div_pending;
    logic div_issued;

    wb_lane_select #(.has_csr(1'b1)) u_lane0 (
        .clk, .aresetn, .lane(lane0), .csr_data, .csr_ready, .quotient, .remainder,
        .div_ready, .dcache_data, .dcache_ready, .wb(wb0), .done(done0)
    );

    // csr only reachable from lane 0
    wb_lane_select #(.has_csr(1'b0)) u_lane1 (
        .clk, .aresetn, .lane(lane1), .csr_data, .csr_ready, .quotient, .remainder,
        .div_ready, .dcache_data, .dcache_ready, .wb(wb1), .done(done1)
    );

    exc_commit u_exc (
        .clk, .aresetn, .exc, .cpu_interrupt, .eentry, .tlbrentry, .exc_out, .pc_from_wb
    );

    assign bubble  = (lane0.inst == '0) && (lane1.inst == '0);
    assign allowin = bubble || (done0 && done1);

    assign div_pending = (lane0.uop.op_class == op_div && !lane0.result_valid) ||
                         (lane1.uop.op_class == op_div && !lane1.result_valid);
    assign div_start   = div_pending && !div_busy && !div_issued;

    // one start per held pair
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            div_issued <= 1'b0;
        end else if (allowin) begin
            div_issued <= 1'b0;
        end else if (div_start) begin
            div_issued <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            dbg_valid <= 1'b0;
        end else begin
            dbg_valid <= allowin;
        end
    end

    always_ff @(posedge clk) begin
        dbg0_pc   <= lane0.pc;
        dbg0_inst <= lane0.inst;
        dbg1_pc   <= lane1.pc;
        dbg1_inst <= lane1.inst;
    end

endmodule

// File: verilog/wb_top.sv
`timescale 1ns/10ps

module wb_top
    import wb_pkg::*;
#(
    parameter int div_iters = 32
) (
    input  logic        clk,
    input  logic        aresetn,
    input  lane_in_t    lane0,
    input  lane_in_t    lane1,
    input  logic [31:0] div_a,
    input  logic [31:0] div_b,
    input  logic [31:0] csr_data,
    input  logic        csr_ready,
    input  logic [31:0] dcache_data,
    input  logic        dcache_ready,
    input  exc_in_t     exc,
    input  logic        cpu_interrupt,
    input  logic [31:0] eentry,
    input  logic [31:0] tlbrentry,
    input  logic [4:0]  rd_addr0,
    input  logic [4:0]  rd_addr1,
    output logic        allowin,
    output wb_port_t    wb0,
    output wb_port_t    wb1,
    output exc_out_t    exc_out,
    output logic [31:0] pc_from_wb,
    output logic [31:0] dbg0_pc,
    output logic [31:0] dbg0_inst,
    output logic [31:0] dbg1_pc,
    output logic [31:0] dbg1_inst,
    output logic        dbg_valid,
    output logic [31:0] rd_data0,
    output logic [31:0] rd_data1
);
    logic        div_start;
    logic        div_busy;
    logic        div_ready;
    logic [31:0] quotient;
    logic [31:0] remainder;

    ex2_wb_stage u_stage (
        .clk, .aresetn, .lane0, .lane1, .csr_data, .csr_ready, .dcache_data, .dcache_ready,
        .quotient, .remainder, .div_ready, .div_busy, .exc, .cpu_interrupt, .eentry,
        .tlbrentry, .allowin, .div_start, .wb0, .wb1, .exc_out, .pc_from_wb,
        .dbg0_pc, .dbg0_inst, .dbg1_pc, .dbg1_inst, .dbg_valid
    );

    iter_divider #(.div_iters(div_iters)) u_div (
        .clk, .aresetn, .start(div_start), .dividend(div_a), .divisor(div_b),
        .quotient, .remainder, .busy(div_busy), .ready(div_ready)
    );

    dual_regfile u_rf (
        .clk, .aresetn, .wb0, .wb1, .rd_addr0, .rd_addr1, .rd_data0, .rd_data1
    );

endmodule

// File: verif/wb_checker.sv
`timescale 1ns/10ps

module wb_checker
    import wb_pkg::*;
(
    input  logic        clk,
    input  wb_port_t    wb0,
    input  wb_port_t    wb1,
    input  exc_out_t    exc_out,
    input  logic [31:0] pc_from_wb,
    input  logic [31:0] rd_data0,
    input  logic [31:0] rd_data1,
    input  logic [31:0] dbg0_pc,
    input  logic [31:0] dbg0_inst,
    input  logic [31:0] dbg1_pc,
    input  logic [31:0] dbg1_inst,
    input  logic        dbg_valid
);
    int err_cnt;
    int chk_cnt;

    initial begin
        err_cnt = 0;
        chk_cnt = 0;
    end

    task automatic compare_word(string name, string what, logic [31:0] exp, logic [31:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("ERROR %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic compare_bit(string name, string what, logic exp, logic act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("ERROR %s %s: expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_reset_state();
        compare_bit("reset", "wb0.we", 1'b0, wb0.we);
        compare_bit("reset", "wb1.we", 1'b0, wb1.we);
        compare_bit("reset", "flush", 1'b0, exc_out.flush);
        compare_bit("reset", "wen_badv", 1'b0, exc_out.wen_badv);
        compare_bit("reset", "wen_vppn", 1'b0, exc_out.wen_vppn);
        compare_bit("reset", "wen_era", 1'b0, exc_out.wen_era);
        compare_bit("reset", "dbg_valid", 1'b0, dbg_valid);
    endtask

    task automatic check_wb(string name, wb_port_t exp0, wb_port_t exp1);
        compare_bit(name, "wb0.we", exp0.we, wb0.we);
        if (exp0.we) begin
            compare_word(name, "wb0.rd", 32'(exp0.rd), 32'(wb0.rd));
            compare_word(name, "wb0.data", exp0.data, wb0.data);
        end
        compare_bit(name, "wb1.we", exp1.we, wb1.we);
        if (exp1.we) begin
            compare_word(name, "wb1.rd", 32'(exp1.rd), 32'(wb1.rd));
            compare_word(name, "wb1.data", exp1.data, wb1.data);
        end
    endtask

    task automatic check_exc(string name, logic flush, logic wbadv, logic wvppn, logic wera,
                             logic refill, logic [31:0] pc, exc_in_t src);
        compare_bit(name, "flush", flush, exc_out.flush);
        compare_bit(name, "wen_badv", wbadv, exc_out.wen_badv);
        compare_bit(name, "wen_vppn", wvppn, exc_out.wen_vppn);
        compare_bit(name, "wen_era", wera, exc_out.wen_era);
        compare_bit(name, "tlb_refill", refill, exc_out.tlb_refill);
        compare_word(name, "pc_from_wb", pc, pc_from_wb);
        if (src.flag) begin
            compare_word(name, "ecode", 32'(src.ecode), 32'(exc_out.ecode));
        end
        if (wbadv) begin
            compare_word(name, "badv", src.badv, exc_out.badv);
        end
        if (wvppn) begin
            compare_word(name, "vppn", 32'(src.badv[18:0]), 32'(exc_out.vppn));
        end
        if (wera) begin
            compare_word(name, "era", src.era, exc_out.era);
        end
    endtask

    task automatic check_rf(string name, logic [31:0] exp0, logic [31:0] exp1);
        compare_word(name, "rd_data0", exp0, rd_data0);
        compare_word(name, "rd_data1", exp1, rd_data1);
    endtask

    // trace registers follow the lanes every cycle
    task automatic check_trace(string name, logic valid, lane_in_t l0, lane_in_t l1);
        compare_bit(name, "dbg_valid", valid, dbg_valid);
        compare_word(name, "dbg0_pc", l0.pc, dbg0_pc);
        compare_word(name, "dbg0_inst", l0.inst, dbg0_inst);
        compare_word(name, "dbg1_pc", l1.pc, dbg1_pc);
        compare_word(name, "dbg1_inst", l1.inst, dbg1_inst);
    endtask

    task automatic check_stall(string name, int exp, int act);
        compare_word(name, "stall cycles", 32'(exp), 32'(act));
    endtask

    task automatic report_stuck(string name);
        err_cnt++;
        $display("allowin stayed low far too long in test %s, moving on", name);
    endtask

    // r0 never appears on a write port
    always @(negedge clk) begin
        if ((wb0.we && wb0.rd == 5'd0) || (wb1.we && wb1.rd == 5'd0)) begin
            err_cnt++;
            $display("a write port was enabled for register r0");
        end
    end

endmodule

// File: verif/tb_wb_top.sv
`timescale 1ns/10ps

module tb_wb_top
    import wb_pkg::*;
();
    localparam int div_iters = 32;
    localparam logic [31:0] eentry_pc = 32'h1c00_8000;
    localparam logic [31:0] tlbr_pc = 32'h1c00_f000;

    typedef struct packed {
        lane_in_t    l0;
        lane_in_t    l1;
        logic [31:0] div_a;
        logic [31:0] div_b;
        logic [31:0] csr_d;
        logic [31:0] dc_d;
        logic        csr_stb;
        logic        dc_stb;
        // cycles allowin stays low, strobes fire on the last one
        int          delay;
        exc_in_t     exc;
        logic        intr;
        logic [4:0]  ra0;
        logic [4:0]  ra1;
        logic [31:0] exp_rd0;
        logic [31:0] exp_rd1;
        wb_port_t    exp_wb0;
        wb_port_t    exp_wb1;
        logic        exp_flush;
        logic        exp_wbadv;
        logic        exp_wvppn;
        logic        exp_wera;
        logic        exp_refill;
        logic [31:0] exp_pc;
    } entry_t;

    logic        clk;
    logic        aresetn;
    lane_in_t    lane0;
    lane_in_t    lane1;
    logic [31:0] div_a;
    logic [31:0] div_b;
    logic [31:0] csr_data;
    logic        csr_ready;
    logic [31:0] dcache_data;
    logic        dcache_ready;
    exc_in_t     exc;
    logic        cpu_interrupt;
    logic [31:0] eentry;
    logic [31:0] tlbrentry;
    logic [4:0]  rd_addr0;
    logic [4:0]  rd_addr1;
    logic        allowin;
    wb_port_t    wb0;
    wb_port_t    wb1;
    exc_out_t    exc_out;
    logic [31:0] pc_from_wb;
    logic [31:0] dbg0_pc;
    logic [31:0] dbg0_inst;
    logic [31:0] dbg1_pc;
    logic [31:0] dbg1_inst;
    logic        dbg_valid;
    logic [31:0] rd_data0;
    logic [31:0] rd_data1;

    entry_t tbl [16];
    string  names [16];
    int     n_entries;
    int     seed;
    int     limit;
    int     cycles;

    wb_top #(.div_iters(div_iters)) dut0 (.*);

    wb_checker checker0 (
        .clk, .wb0, .wb1, .exc_out, .pc_from_wb, .rd_data0, .rd_data1, .dbg0_pc,
        .dbg0_inst, .dbg1_pc, .dbg1_inst, .dbg_valid
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic lane_in_t make_lane(logic [31:0] pc, op_class_e cls, logic rem,
                                           logic [4:0] rd, logic [31:0] res);
        lane_in_t l;
        l.pc           = pc;
        l.inst         = pc ^ 32'h0280_0001;
        l.uop.op_class = cls;
        l.uop.div_rem  = rem;
        l.rd           = rd;
        l.result       = res;
        l.result_valid = (cls == op_alu);
        return l;
    endfunction

    // unsigned division with all ones and the dividend back on a zero divisor
    function automatic logic [31:0] expected_division(logic [31:0] a, logic [31:0] b,
                                                      logic rem);
        if (b == 32'd0) begin
            return rem ? a : 32'hffff_ffff;
        end
        return rem ? (a % b) : (a / b);
    endfunction

    function automatic wb_port_t write_port(logic [4:0] rd, logic [31:0] data);
        wb_port_t p;
        p.we   = (rd != 5'd0);
        p.rd   = rd;
        p.data = data;
        return p;
    endfunction

    function automatic wb_port_t expected_port(lane_in_t l, entry_t e, bit first_lane);
        case (l.uop.op_class)
            op_alu:  return write_port(l.rd, l.result);
            op_csr:  return first_lane ? write_port(l.rd, e.csr_d) : '0;
            op_div:  return write_port(l.rd,
                                       expected_division(e.div_a, e.div_b, l.uop.div_rem));
            op_load: return write_port(l.rd, e.dc_d);
            default: return '0;
        endcase
    endfunction

    function automatic entry_t blank();
        entry_t e;
        e           = '0;
        e.exc.ecode = exp_none;
        return e;
    endfunction

    task automatic push_entry(string name, entry_t e, logic [4:0] ra0, logic [31:0] v0,
                              logic [4:0] ra1, logic [31:0] v1);
        logic page;
        logic addr;
        page         = e.exc.ecode inside {exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi, exp_tlbr};
        addr         = page || (e.exc.ecode inside {exp_adef, exp_ale});
        e.ra0        = ra0;
        e.ra1        = ra1;
        e.exp_rd0    = v0;
        e.exp_rd1    = v1;
        e.exp_wb0    = expected_port(e.l0, e, 1'b1);
        e.exp_wb1    = expected_port(e.l1, e, 1'b0);
        e.exp_flush  = e.exc.flag || e.intr;
        e.exp_wbadv  = e.exc.flag && addr;
        e.exp_wvppn  = e.exc.flag && page;
        e.exp_wera   = e.exp_flush;
        e.exp_refill = e.exc.flag && (e.exc.ecode == exp_tlbr);
        e.exp_pc     = e.exp_refill ? tlbr_pc : eentry_pc;
        tbl[n_entries]   = e;
        names[n_entries] = name;
        n_entries++;
    endtask

    task automatic push_exc(string name, logic flag, ecode_e code, logic intr);
        entry_t e;
        e           = blank();
        e.exc.flag  = flag;
        e.exc.ecode = code;
        e.exc.badv  = $random(seed);
        e.exc.era   = 32'h1c00_1000 + 32'(n_entries * 4);
        e.intr      = intr;
        push_entry(name, e, 5'd0, 32'd0, 5'd0, 32'd0);
    endtask

    task automatic build_table();
        entry_t      e;
        logic [31:0] x;
        logic [31:0] y;
        n_entries = 0;
        x    = $random(seed);
        y    = $random(seed);
        e    = blank();
        e.l0 = make_lane(32'h1c00_0000, op_alu, 1'b0, 5'd1, x);
        e.l1 = make_lane(32'h1c00_0004, op_alu, 1'b0, 5'd2, y);
        push_entry("alu_both", e, 5'd1, x, 5'd2, y);
        e    = blank();
        e.l0 = make_lane(32'h1c00_0008, op_alu, 1'b0, 5'd0, 32'hdead_beef);
        e.l1 = make_lane(32'h1c00_000c, op_alu, 1'b0, 5'd3, 32'h0000_5a5a);
        push_entry("alu_r0", e, 5'd0, 32'd0, 5'd3, 32'h0000_5a5a);
        x    = $random(seed);
        y    = $random(seed);
        e    = blank();
        e.l0 = make_lane(32'h1c00_0010, op_alu, 1'b0, 5'd5, x);
        e.l1 = make_lane(32'h1c00_0014, op_alu, 1'b0, 5'd5, y);
        push_entry("alu_same_rd", e, 5'd5, y, 5'd5, y);
        // divider answers div_iters+1 cycles after its start
        e            = blank();
        e.div_a      = $random(seed);
        e.div_b      = ($random(seed) >> 20) | 32'd1;
        e.delay      = div_iters + 1;
        e.l0         = make_lane(32'h1c00_0018, op_div, 1'b0, 5'd6, 32'd0);
        push_entry("div_quot_lane0", e, 5'd6, expected_division(e.div_a, e.div_b, 1'b0),
                   5'd0, 32'd0);
        e            = blank();
        e.div_a      = $random(seed);
        e.div_b      = ($random(seed) >> 16) | 32'd1;
        e.delay      = div_iters + 1;
        e.l0         = make_lane(32'h1c00_001c, op_alu, 1'b0, 5'd8, 32'h0000_0808);
        e.l1         = make_lane(32'h1c00_0020, op_div, 1'b1, 5'd7, 32'd0);
        push_entry("div_rem_lane1", e, 5'd7, expected_division(e.div_a, e.div_b, 1'b1),
                   5'd8, 32'h0000_0808);
        e            = blank();
        e.div_a      = $random(seed);
        e.delay      = div_iters + 1;
        e.l0         = make_lane(32'h1c00_0024, op_div, 1'b0, 5'd9, 32'd0);
        e.l1         = make_lane(32'h1c00_0028, op_div, 1'b1, 5'd10, 32'd0);
        push_entry("div_by_zero", e, 5'd9, 32'hffff_ffff, 5'd10, e.div_a);
        e            = blank();
        e.div_a      = 32'd100;
        e.div_b      = 32'd7;
        e.delay      = div_iters + 1;
        e.l0         = make_lane(32'h1c00_002c, op_div, 1'b0, 5'd11, 32'd0);
        e.l1         = make_lane(32'h1c00_0030, op_div, 1'b1, 5'd12, 32'd0);
        push_entry("div_small", e, 5'd11, 32'd14, 5'd12, 32'd2);
        e            = blank();
        e.dc_d       = $random(seed);
        e.dc_stb     = 1'b1;
        e.delay      = 2;
        e.l0         = make_lane(32'h1c00_0034, op_store, 1'b0, 5'd0, 32'd0);
        e.l1         = make_lane(32'h1c00_0038, op_load, 1'b0, 5'd13, 32'd0);
        push_entry("load_lane1", e, 5'd13, e.dc_d, 5'd0, 32'd0);
        e            = blank();
        e.csr_d      = $random(seed);
        e.dc_d       = $random(seed);
        e.csr_stb    = 1'b1;
        e.dc_stb     = 1'b1;
        e.delay      = 3;
        e.l0         = make_lane(32'h1c00_003c, op_csr, 1'b0, 5'd14, 32'd0);
        e.l1         = make_lane(32'h1c00_0040, op_load, 1'b0, 5'd15, 32'd0);
        push_entry("csr_and_load", e, 5'd14, e.csr_d, 5'd15, e.dc_d);
        e            = blank();
        e.dc_d       = $random(seed);
        e.dc_stb     = 1'b1;
        e.l0         = make_lane(32'h1c00_0044, op_load, 1'b0, 5'd16, 32'd0);
        push_entry("load_no_wait", e, 5'd16, e.dc_d, 5'd0, 32'd0);
        push_exc("exc_tlbr", 1'b1, exp_tlbr, 1'b0);
        push_exc("exc_pif", 1'b1, exp_pif, 1'b0);
        push_exc("exc_ale", 1'b1, exp_ale, 1'b0);
        push_exc("exc_sys", 1'b1, exp_sys, 1'b0);
        push_exc("interrupt", 1'b0, exp_none, 1'b1);
    endtask

    task automatic drive_idle();
        lane0         = '0;
        lane1         = '0;
        csr_ready     = 1'b0;
        dcache_ready  = 1'b0;
        exc           = '0;
        exc.ecode     = exp_none;
        cpu_interrupt = 1'b0;
    endtask

    task automatic run_entry(int idx);
        entry_t e;
        int     stall;
        bit     stuck;
        e     = tbl[idx];
        stall = 0;
        stuck = 1'b0;
        @(posedge clk);
        #1;
        lane0         = e.l0;
        lane1         = e.l1;
        div_a         = e.div_a;
        div_b         = e.div_b;
        csr_data      = e.csr_d;
        dcache_data   = e.dc_d;
        exc           = e.exc;
        cpu_interrupt = e.intr;
        rd_addr0      = e.ra0;
        rd_addr1      = e.ra1;
        csr_ready     = e.csr_stb && (e.delay == 0);
        dcache_ready  = e.dc_stb && (e.delay == 0);
        @(negedge clk);
        while (!allowin && !stuck) begin
            stall++;
            @(posedge clk);
            #1;
            csr_ready    = e.csr_stb && (stall == e.delay);
            dcache_ready = e.dc_stb && (stall == e.delay);
            @(negedge clk);
            checker0.check_trace(names[idx], 1'b0, e.l0, e.l1);
            if (stall > div_iters + 4) begin
                stuck = 1'b1;
            end
        end
        if (stuck) begin
            checker0.report_stuck(names[idx]);
        end else begin
            checker0.check_stall(names[idx], e.delay, stall);
        end
        // pair accepted on this edge
        @(posedge clk);
        #1;
        drive_idle();
        @(negedge clk);
        checker0.check_wb(names[idx], e.exp_wb0, e.exp_wb1);
        checker0.check_exc(names[idx], e.exp_flush, e.exp_wbadv, e.exp_wvppn, e.exp_wera,
                           e.exp_refill, e.exp_pc, e.exc);
        checker0.check_trace(names[idx], 1'b1, e.l0, e.l1);
        @(posedge clk);
        @(negedge clk);
        checker0.check_rf(names[idx], e.exp_rd0, e.exp_rd1);
    endtask

    initial begin
        cycles = 0;
        @(posedge aresetn);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the test table did not complete", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed        = 53;
        aresetn     = 1'b0;
        div_a       = '0;
        div_b       = '0;
        csr_data    = '0;
        dcache_data = '0;
        eentry      = eentry_pc;
        tlbrentry   = tlbr_pc;
        rd_addr0    = '0;
        rd_addr1    = '0;
        drive_idle();
        build_table();
        limit = n_entries * (div_iters + 8);
        repeat (8) @(posedge clk);
        #1;
        aresetn = 1'b1;
        @(negedge clk);
        checker0.check_reset_state();
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("tests: %0d, checks: %0d, errors: %0d", n_entries, checker0.chk_cnt,
                 checker0.err_cnt);
        if (checker0.err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
verilog/wb_pkg.sv
verilog/wb_lane_select.sv
verilog/exc_commit.sv
verilog/iter_divider.sv
verilog/dual_regfile.sv
verilog/ex2_wb_stage.sv
verilog/wb_top.sv
verif/wb_checker.sv
verif/tb_wb_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_wb_top -o sim_wb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_wb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
